//--- pixel_pipe.f
pixel_pipe_pkg.sv
lane_stage.sv
pipe_ctrl.sv
pixel_packer.sv
pixel_pipe.sv
pixel_pipe_props.sv
tb_pixel_pipe.sv

//--- Bender.yml
package:
  name: pixel_pipe

sources:
  - pixel_pipe_pkg.sv
  - lane_stage.sv
  - pipe_ctrl.sv
  - pixel_packer.sv
  - pixel_pipe.sv
  - target: test
    files:
      - pixel_pipe_props.sv
      - tb_pixel_pipe.sv

//--- tb_pixel_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pixel_pipe;

    import pixel_pipe_pkg::*;

    localparam int          FRAC_BITS = 4;
    localparam int          NROWS     = 6;
    localparam logic [31:0] SEED      = 32'h80112319;

    // gain, offset, frame bytes, input words, out_ready stall threshold
    typedef struct packed {
        gain_t       gain;
        pix_t        offset;
        frame_len_t  frame_bytes;
        logic [15:0] n_words;
        logic [7:0]  stall;
    } row_t;

    logic       fclk = 1'b0;
    logic       arst_n;
    cmd_t       cmd;
    logic       cmd_valid;
    gain_t      gain;
    pix_t       offset;
    frame_len_t frame_bytes;
    logic       in_valid;
    logic       in_ready;
    word_t      in_data;
    logic       out_valid;
    logic       out_ready;
    word_t      out_data;
    logic       frame_done;

    row_t        rows [NROWS];
    word_t       exp_q [$];
    word_t       exp_word;
    logic        exp_fd;
    int          errors;
    int          n_checked;
    int          fd_count;
    int          total_words;
    frame_len_t  frame_words_exp;
    gain_t       cur_gain;
    pix_t        cur_offset;
    logic [31:0] pix_state;
    logic [31:0] stall_state;
    logic [7:0]  stall_thr;

    pixel_pipe #(
        .FRAC_BITS (FRAC_BITS)
    ) pixel_pipe_inst (
        .fclk        (fclk),
        .arst_n      (arst_n),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .gain        (gain),
        .offset      (offset),
        .frame_bytes (frame_bytes),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_data     (in_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .frame_done  (frame_done)
    );

    always #20 fclk = ~fclk;

    // --------------------------------------------------
    // stimulus helpers and reference model
    // --------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // gain has FRAC_BITS fraction bits, result clamps at full scale
    function automatic pix_t model_pixel(input pix_t p, input gain_t g, input pix_t o);
        int v;
        v = ((int'(p) * int'(g)) >> FRAC_BITS) + int'(o);
        if (v > 255) begin
            v = 255;
        end
        return pix_t'(v);
    endfunction

    task automatic gen_word(output word_t w);
        pix_state = lcg_next(pix_state);
        w[31:0] = pix_state;
        pix_state = lcg_next(pix_state);
        w[63:32] = pix_state;
    endtask

    // four padded output words per input word, low parcel first
    task automatic push_expected(input word_t w);
        word_t r;
        pix_t  lo;
        pix_t  hi;
        for (int i = 0; i < LANES; i++) begin
            r[i*8 +: 8] = model_pixel(w[i*8 +: 8], cur_gain, cur_offset);
        end
        for (int k = 0; k < PARCELS; k++) begin
            lo = r[k*16 +: 8];
            hi = r[k*16 + 8 +: 8];
            exp_q.push_back({8'h00, hi, hi, hi, 8'h00, lo, lo, lo});
        end
    endtask

    task automatic start_row(input int r);
        @(negedge fclk);
        gain            = rows[r].gain;
        offset          = rows[r].offset;
        frame_bytes     = rows[r].frame_bytes;
        cur_gain        = rows[r].gain;
        cur_offset      = rows[r].offset;
        frame_words_exp = rows[r].frame_bytes / 8;
        fd_count        = 0;
        cmd             = CMD_START;
        cmd_valid       = 1'b1;
        @(negedge fclk);
        cmd_valid = 1'b0;
    endtask

    task automatic stop_run();
        @(negedge fclk);
        in_valid  = 1'b0;
        cmd       = CMD_STOP;
        cmd_valid = 1'b1;
        @(negedge fclk);
        cmd_valid = 1'b0;
    endtask

    task automatic send_words(input int n);
        word_t w;
        for (int i = 0; i < n; i++) begin
            @(negedge fclk);
            gen_word(w);
            // occasional bubble on the input
            if (w[7:5] == 3'b000) begin
                in_valid = 1'b0;
                @(negedge fclk);
            end
            in_valid = 1'b1;
            in_data  = w;
            @(posedge fclk);
            while (!in_ready) begin
                @(posedge fclk);
            end
            push_expected(w);
        end
    endtask

    // words offered here must never be taken
    task automatic offer_while_idle(input int n);
        word_t w;
        repeat (n) begin
            @(negedge fclk);
            gen_word(w);
            in_valid = 1'b1;
            in_data  = w;
            @(posedge fclk);
            if (in_ready !== 1'b0) begin
                errors++;
                $display("ERROR t=%0t in_ready expected 0 got %b", $time, in_ready);
            end
        end
        @(negedge fclk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        @(negedge fclk);
        while (exp_q.size() != 0) begin
            @(negedge fclk);
        end
        @(posedge fclk);
    endtask

    // random out_ready stalls
    always @(negedge fclk) begin
        stall_state = lcg_next(stall_state);
        out_ready   = (stall_state[23:16] >= stall_thr);
    end

    // --------------------------------------------------
    // output monitor
    // --------------------------------------------------
    always @(posedge fclk) begin
        if (arst_n) begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR t=%0t output word %h accepted with none expected",
                             $time, out_data);
                end else begin
                    exp_word = exp_q.pop_front();
                    n_checked++;
                    if (out_data !== exp_word) begin
                        errors++;
                        $display("ERROR t=%0t out_data expected %h got %h",
                                 $time, exp_word, out_data);
                    end
                end
                exp_fd   = (fd_count + 1 == int'(frame_words_exp));
                fd_count = exp_fd ? 0 : fd_count + 1;
                if (frame_done !== exp_fd) begin
                    errors++;
                    $display("ERROR t=%0t frame_done expected %b got %b",
                             $time, exp_fd, frame_done);
                end
            end else if (frame_done !== 1'b0) begin
                errors++;
                $display("ERROR t=%0t frame_done expected 0 got %b", $time, frame_done);
            end
        end
    end

    initial begin
        arst_n          = 1'b0;
        cmd             = '0;
        cmd_valid       = 1'b0;
        gain            = '0;
        offset          = '0;
        frame_bytes     = '0;
        in_valid        = 1'b0;
        in_data         = '0;
        out_ready       = 1'b1;
        errors          = 0;
        n_checked       = 0;
        fd_count        = 0;
        frame_words_exp = '0;
        cur_gain        = '0;
        cur_offset      = '0;
        pix_state       = SEED;
        stall_state     = SEED;
        stall_thr       = '0;
        // identity, saturating gain, stalls with partial frame bytes, all clamped
        rows[0] = {8'h10, 8'd0, 32'd32, 16'd6, 8'd0};
        rows[1] = {8'h18, 8'd20, 32'd40, 16'd5, 8'd0};
        rows[2] = {8'h08, 8'd100, 32'd45, 16'd6, 8'd64};
        rows[3] = {8'hff, 8'hff, 32'd24, 16'd4, 8'd48};
        rows[4] = {8'h00, 8'd37, 32'd8, 16'd3, 8'd80};
        rows[5] = {8'h13, 8'd3, 32'd64, 16'd8, 8'd32};

        repeat (2) @(negedge fclk);
        arst_n = 1'b1;
        offer_while_idle(6);

        for (int r = 0; r < NROWS; r++) begin
            wait_drained();
            stall_thr = rows[r].stall;
            start_row(r);
            send_words(rows[r].n_words);
            stop_run();
            offer_while_idle(8);
        end
        wait_drained();
        repeat (4) @(posedge fclk);

        if (n_checked != total_words * PARCELS) begin
            errors++;
            $display("ERROR t=%0t output word count expected %0d got %0d",
                     $time, total_words * PARCELS, n_checked);
        end
        $display("%0d output words checked, %0d errors", n_checked, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // --------------------------------------------------
    // watchdog
    // --------------------------------------------------
    initial begin
        @(posedge arst_n);
        total_words = 0;
        for (int r = 0; r < NROWS; r++) begin
            total_words += rows[r].n_words;
        end
        repeat (total_words * 8 + NROWS * 60 + 100) @(posedge fclk);
        $display("watchdog expired, the run did not finish in time");
        $display("Regression failed");
        $finish;
    end

endmodule : tb_pixel_pipe

`default_nettype wire

//--- pixel_pipe_props.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_pipe_props (
    input logic                  fclk,
    input logic                  arst_n,
    input pixel_pipe_pkg::cmd_t  cmd,
    input logic                  cmd_valid,
    input logic                  in_ready,
    input logic                  out_valid,
    input logic                  out_ready,
    input pixel_pipe_pkg::word_t out_data,
    input logic                  frame_done
);

    import pixel_pipe_pkg::*;

    // run state as seen from the command port
    logic started;

    always_ff @(posedge fclk or negedge arst_n) begin
        if (!arst_n) begin
            started <= 1'b0;
        end else if (cmd_valid && (cmd == CMD_START)) begin
            started <= 1'b1;
        end else if (cmd_valid && (cmd == CMD_STOP)) begin
            started <= 1'b0;
        end
    end

    // stalled output word holds until the sink takes it
    a_out_held: assert property (@(posedge fclk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_data or out_valid changed while out_ready was low");

    a_done_on_accept: assert property (@(posedge fclk) disable iff (!arst_n)
        frame_done |-> out_valid && out_ready)
        else $error("frame_done pulsed without an accepted output word");

    // no input taken while stopped
    a_idle_not_ready: assert property (@(posedge fclk) disable iff (!arst_n)
        !started |-> !in_ready)
        else $error("in_ready high while the run state is idle");

    a_valid_known: assert property (@(posedge fclk) disable iff (!arst_n)
        !$isunknown(out_valid))
        else $error("out_valid is unknown after reset");

endmodule : pixel_pipe_props

bind pixel_pipe pixel_pipe_props props_inst (
    .fclk       (fclk),
    .arst_n     (arst_n),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .frame_done (frame_done)
);

`default_nettype wire

//--- pixel_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_pipe #(
    parameter int FRAC_BITS = 4
) (
    input  logic                       fclk,
    input  logic                       arst_n,
    input  pixel_pipe_pkg::cmd_t       cmd,
    input  logic                       cmd_valid,
    input  pixel_pipe_pkg::gain_t      gain,
    input  pixel_pipe_pkg::pix_t       offset,
    input  pixel_pipe_pkg::frame_len_t frame_bytes,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  pixel_pipe_pkg::word_t      in_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output pixel_pipe_pkg::word_t      out_data,
    output logic                       frame_done
);

    import pixel_pipe_pkg::*;

    logic       advance;
    logic       stage2_valid;
    logic       packer_ready;
    logic       run_start;
    gain_t      lane_gain;
    pix_t       lane_offset;
    frame_len_t frame_words;
    word_t      lane_word;

    pipe_ctrl ctrl_inst (
        .fclk         (fclk),
        .arst_n       (arst_n),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .gain         (gain),
        .offset       (offset),
        .frame_bytes  (frame_bytes),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .packer_ready (packer_ready),
        .advance      (advance),
        .lane_gain    (lane_gain),
        .lane_offset  (lane_offset),
        .stage2_valid (stage2_valid),
        .run_start    (run_start),
        .frame_words  (frame_words)
    );

    // --------------------------------------------------
    // one pointwise lane per byte of the input word
    // --------------------------------------------------
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        lane_stage #(
            .FRAC_BITS (FRAC_BITS)
        ) lane_inst (
            .fclk    (fclk),
            .arst_n  (arst_n),
            .advance (advance),
            .gain    (lane_gain),
            .offset  (lane_offset),
            .pix_in  (in_data[i*8 +: 8]),
            .pix_out (lane_word[i*8 +: 8])
        );
    end

    pixel_packer packer_inst (
        .fclk         (fclk),
        .arst_n       (arst_n),
        .word_valid   (stage2_valid),
        .word         (lane_word),
        .packer_ready (packer_ready),
        .run_start    (run_start),
        .frame_words  (frame_words),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data),
        .frame_done   (frame_done)
    );

endmodule : pixel_pipe

`default_nettype wire

//--- pixel_packer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_packer (
    input  logic                       fclk,
    input  logic                       arst_n,
    input  logic                       word_valid,
    input  pixel_pipe_pkg::word_t      word,
    output logic                       packer_ready,
    input  logic                       run_start,
    input  pixel_pipe_pkg::frame_len_t frame_words,
    output logic                       out_valid,
    input  logic                       out_ready,
    output pixel_pipe_pkg::word_t      out_data,
    output logic                       frame_done
);

    import pixel_pipe_pkg::*;

    localparam int IDX_W   = $clog2(PARCELS);
    localparam int PARCEL_W = $bits(parcel_t);

    word_t            word_q;
    logic [IDX_W-1:0] idx;
    parcel_t          parcel;
    logic             accept;
    logic             last;
    logic             load;
    frame_len_t       word_cnt;
    frame_len_t       word_cnt_next;

    // --------------------------------------------------
    // 64 to 16 serializer
    // --------------------------------------------------
    assign accept = out_valid && out_ready;
    assign last   = (idx == IDX_W'(PARCELS - 1));

    // empty, or the last parcel leaves in this cycle
    assign packer_ready = !out_valid || (accept && last);
    assign load         = word_valid && packer_ready;

    always_ff @(posedge fclk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            idx       <= '0;
        end else if (load) begin
            out_valid <= 1'b1;
            idx       <= '0;
        end else if (accept) begin
            if (last) begin
                out_valid <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    always_ff @(posedge fclk) begin
        if (load) begin
            word_q <= word;
        end
    end

    // parcel 0 sits in the low bits
    assign parcel = word_q[idx*PARCEL_W +: PARCEL_W];

    // padded layout: zero byte over three copies of each pixel
    assign out_data = {
        8'h00, {3{parcel[15:8]}},
        8'h00, {3{parcel[7:0]}}
    };

    // --------------------------------------------------
    // frame word counter
    // --------------------------------------------------
    assign word_cnt_next = word_cnt + 1'b1;
    assign frame_done    = accept && (word_cnt_next == frame_words);

    always_ff @(posedge fclk or negedge arst_n) begin
        if (!arst_n) begin
            word_cnt <= '0;
        end else if (run_start) begin
            word_cnt <= '0;
        end else if (accept) begin
            // wrap so the next frame follows directly
            if (frame_done) begin
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt_next;
            end
        end
    end

endmodule : pixel_packer

`default_nettype wire

//--- pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
    input  logic                       fclk,
    input  logic                       arst_n,
    input  pixel_pipe_pkg::cmd_t       cmd,
    input  logic                       cmd_valid,
    input  pixel_pipe_pkg::gain_t      gain,
    input  pixel_pipe_pkg::pix_t       offset,
    input  pixel_pipe_pkg::frame_len_t frame_bytes,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic                       packer_ready,
    output logic                       advance,
    output pixel_pipe_pkg::gain_t      lane_gain,
    output pixel_pipe_pkg::pix_t       lane_offset,
    output logic                       stage2_valid,
    output logic                       run_start,
    output pixel_pipe_pkg::frame_len_t frame_words
);

    import pixel_pipe_pkg::*;

    run_state_t state;
    logic       start_cmd;
    logic       stop_cmd;
    logic       stage1_valid;

    assign start_cmd = cmd_valid && (cmd == CMD_START);
    assign stop_cmd  = cmd_valid && (cmd == CMD_STOP);

    // --------------------------------------------------
    // run state
    // --------------------------------------------------
    always_ff @(posedge fclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= idle;
            run_start <= 1'b0;
        end else begin
            run_start <= start_cmd;
            if (start_cmd) begin
                state <= running;
            end else if (stop_cmd) begin
                state <= idle;
            end
        end
    end

    // lane parameters and frame length, taken at start only
    always_ff @(posedge fclk) begin
        if (start_cmd) begin
            lane_gain   <= gain;
            lane_offset <= offset;
            // eight bytes per stream word, partial word dropped
            frame_words <= frame_bytes >> 3;
        end
    end

    // --------------------------------------------------
    // valid bits alongside the two lane stages
    // --------------------------------------------------
    // stage 2 moves on when empty or when the packer takes its word
    assign advance  = !stage2_valid || packer_ready;
    assign in_ready = (state == running) && advance;

    always_ff @(posedge fclk or negedge arst_n) begin
        if (!arst_n) begin
            stage1_valid <= 1'b0;
            stage2_valid <= 1'b0;
        end else if (advance) begin
            // words in flight keep draining after a stop
            stage1_valid <= in_valid && in_ready;
            stage2_valid <= stage1_valid;
        end
    end

endmodule : pipe_ctrl

`default_nettype wire

//--- lane_stage.sv
`timescale 1ns/1ps
`default_nettype none

module lane_stage #(
    parameter int FRAC_BITS = 4
) (
    input  logic                  fclk,
    input  logic                  arst_n,
    input  logic                  advance,
    input  pixel_pipe_pkg::gain_t gain,
    input  pixel_pipe_pkg::pix_t  offset,
    input  pixel_pipe_pkg::pix_t  pix_in,
    output pixel_pipe_pkg::pix_t  pix_out
);

    logic [15:0] product;
    logic [15:0] scaled;
    // one extra bit for the carry out of the offset add
    logic [16:0] sum;

    assign scaled = product >> FRAC_BITS;
    assign sum    = {1'b0, scaled} + {9'd0, offset};

    // stage 1: full precision product
    always_ff @(posedge fclk or negedge arst_n) begin
        if (!arst_n) begin
            product <= '0;
        end else if (advance) begin
            product <= pix_in * gain;
        end
    end

    // stage 2: drop fraction, add offset, saturate
    always_ff @(posedge fclk or negedge arst_n) begin
        if (!arst_n) begin
            pix_out <= '0;
        end else if (advance) begin
            if (sum > 17'd255) begin
                pix_out <= 8'hff;
            end else begin
                pix_out <= sum[7:0];
            end
        end
    end

endmodule : lane_stage

`default_nettype wire

//--- pixel_pipe_pkg.sv
`default_nettype none

package pixel_pipe_pkg;

    // --------------------------------------------------
    // stream and pixel widths
    // --------------------------------------------------
    typedef logic [7:0]  pix_t;
    typedef logic [63:0] word_t;
    // two pixels, one serializer slot
    typedef logic [15:0] parcel_t;
    // unsigned fixed point, FRAC_BITS fractional bits
    typedef logic [7:0]  gain_t;
    typedef logic [31:0] cmd_t;
    // frame length in bytes, also used for the word count
    typedef logic [31:0] frame_len_t;

    typedef enum logic {
        idle,
        running
    } run_state_t;

    localparam int LANES   = 8;
    localparam int PARCELS = 4;

    // command codes, same values as the register interface
    localparam cmd_t CMD_START = 32'd1;
    localparam cmd_t CMD_STOP  = 32'd2;

endpackage : pixel_pipe_pkg

`default_nettype wire
